// ==== common/nocPkg.sv ====
package nocPkg;

  // flit format
  localparam int flitWidth = 32;

  // --------------------
  // field positions
  // --------------------
  localparam int idMsb = 31;
  localparam int idLsb = 29;
  localparam int lenMsb = 28;  // header only
  localparam int lenLsb = 17;

  // widths with a meaning
  typedef logic [flitWidth-1:0] flitT;
  typedef logic [idMsb-idLsb:0] flitIdT;
  typedef logic [lenMsb-lenLsb:0] lengthT;

  // --------------------
  // flit identifier codes
  // --------------------
  localparam flitIdT idHeader = 3'd1;
  localparam flitIdT idBody = 3'd2;
  localparam flitIdT idTail = 3'd4;
  // any other code is invalid

endpackage

// ==== common/arbPkg.sv ====
package arbPkg;

  localparam int numPorts = 5;

  // input order, also the fixed priority from idle
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  typedef logic [numPorts-1:0] grantT;  // one bit per input

  // one-hot, bit 0 is idle and bits 5..1 follow the port order
  typedef enum logic [numPorts:0] {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbStateT;

endpackage

// ==== verilog/flitDecode.sv ====
`timescale 1ns/1ps

module flitDecode (
  input  logic           clk,
  input  logic           rst,
  input  nocPkg::flitT   inFlit,
  input  logic           inValid,
  input  logic           accepted,
  output logic           req,
  output nocPkg::flitIdT flitId,
  output nocPkg::lengthT length,
  output logic           framingError
);

  logic inPacket;
  logic isHeader;
  logic isBody;
  logic isTail;
  logic badFlit;

  // --------------------
  // header fields
  // --------------------
  assign flitId = inFlit[nocPkg::idMsb:nocPkg::idLsb];
  assign length = inFlit[nocPkg::lenMsb:nocPkg::lenLsb];

  assign isHeader = (flitId == nocPkg::idHeader);
  assign isBody = (flitId == nocPkg::idBody);
  assign isTail = (flitId == nocPkg::idTail);

  // a header may always open a packet, body and tail only inside one
  assign req = inValid && (isHeader || (inPacket && (isBody || isTail)));
  assign badFlit = inValid && !req;  // stray or unknown id

  // --------------------
  // packet framing
  // --------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inPacket <= 1'b0;
      framingError <= 1'b0;
    end
    else
    begin
      framingError <= badFlit;
      if (accepted && req)
      begin
        if (isHeader)
          inPacket <= 1'b1;
        else if (isTail)
          inPacket <= 1'b0;  // packet done
      end
    end
  end

endmodule

// ==== arbiter/grantTimer.sv ====
`timescale 1ns/1ps

module grantTimer (
  input  logic           clk,
  input  logic           rst,
  input  nocPkg::flitIdT flitId,
  input  nocPkg::lengthT length,
  input  logic           run,
  output logic           timesUp
);

  nocPkg::lengthT limit;  // held cycles allowed
  nocPkg::lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == nocPkg::idHeader)
        limit <= length;  // new packet, new budget
      if (run)
        count <= count + 12'd1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

// ==== arbiter/portArbiter.sv ====
`timescale 1ns/1ps

module portArbiter (
  input  logic              clk,
  input  logic              rst,
  input  arbPkg::grantT     req,
  input  nocPkg::flitIdT    flitIdL,
  input  nocPkg::flitIdT    flitIdN,
  input  nocPkg::flitIdT    flitIdE,
  input  nocPkg::flitIdT    flitIdW,
  input  nocPkg::flitIdT    flitIdS,
  input  nocPkg::lengthT    lengthL,
  input  nocPkg::lengthT    lengthN,
  input  nocPkg::lengthT    lengthE,
  input  nocPkg::lengthT    lengthW,
  input  nocPkg::lengthT    lengthS,
  output arbPkg::arbStateT  nextState
);

  arbPkg::arbStateT currentState;
  arbPkg::grantT run;
  arbPkg::grantT timesUp;

  // first requester scanning from start, wrapping around the ports
  function automatic arbPkg::arbStateT pickFrom(arbPkg::grantT r, int start);
    logic [arbPkg::numPorts:0] vec;
    int idx;
    pickFrom = arbPkg::stIdle;
    for (int i = arbPkg::numPorts - 1; i >= 0; i--)
    begin
      idx = start + i;
      if (idx >= arbPkg::numPorts)
        idx = idx - arbPkg::numPorts;
      if (r[idx])
      begin
        vec = '0;
        vec[idx+1] = 1'b1;
        pickFrom = arbPkg::arbStateT'(vec);  // lower i overwrites, so it wins
      end
    end
  endfunction

  // --------------------
  // grant timers
  // --------------------
  grantTimer timerL (
    .clk(clk), .rst(rst), .flitId(flitIdL), .length(lengthL),
    .run(run[arbPkg::portL]), .timesUp(timesUp[arbPkg::portL])
  );
  grantTimer timerN (
    .clk(clk), .rst(rst), .flitId(flitIdN), .length(lengthN),
    .run(run[arbPkg::portN]), .timesUp(timesUp[arbPkg::portN])
  );
  grantTimer timerE (
    .clk(clk), .rst(rst), .flitId(flitIdE), .length(lengthE),
    .run(run[arbPkg::portE]), .timesUp(timesUp[arbPkg::portE])
  );
  grantTimer timerW (
    .clk(clk), .rst(rst), .flitId(flitIdW), .length(lengthW),
    .run(run[arbPkg::portW]), .timesUp(timesUp[arbPkg::portW])
  );
  grantTimer timerS (
    .clk(clk), .rst(rst), .flitId(flitIdS), .length(lengthS),
    .run(run[arbPkg::portS]), .timesUp(timesUp[arbPkg::portS])
  );

  // --------------------
  // state register
  // --------------------
  always_ff @(posedge clk)
  begin
    if (rst)
      currentState <= arbPkg::stIdle;
    else
      currentState <= nextState;
  end

  // hold while the owner requests and has budget, else rotate past it
  always_comb
  begin
    run = '0;
    nextState = arbPkg::stIdle;
    case (currentState)
      arbPkg::stIdle:
        nextState = pickFrom(req, arbPkg::portL);
      arbPkg::stLocal:
        if (req[arbPkg::portL] && !timesUp[arbPkg::portL])
        begin
          run[arbPkg::portL] = 1'b1;
          nextState = arbPkg::stLocal;
        end
        else
          nextState = pickFrom(req, arbPkg::portN);
      arbPkg::stNorth:
        if (req[arbPkg::portN] && !timesUp[arbPkg::portN])
        begin
          run[arbPkg::portN] = 1'b1;
          nextState = arbPkg::stNorth;
        end
        else
          nextState = pickFrom(req, arbPkg::portE);
      arbPkg::stEast:
        if (req[arbPkg::portE] && !timesUp[arbPkg::portE])
        begin
          run[arbPkg::portE] = 1'b1;
          nextState = arbPkg::stEast;
        end
        else
          nextState = pickFrom(req, arbPkg::portW);
      arbPkg::stWest:
        if (req[arbPkg::portW] && !timesUp[arbPkg::portW])
        begin
          run[arbPkg::portW] = 1'b1;
          nextState = arbPkg::stWest;
        end
        else
          nextState = pickFrom(req, arbPkg::portS);
      arbPkg::stSouth:
        if (req[arbPkg::portS] && !timesUp[arbPkg::portS])
        begin
          run[arbPkg::portS] = 1'b1;
          nextState = arbPkg::stSouth;
        end
        else
          nextState = pickFrom(req, arbPkg::portL);  // wrap to local
      default:
        nextState = arbPkg::stIdle;
    endcase
  end

endmodule

// ==== verilog/outputMux.sv ====
`timescale 1ns/1ps

module outputMux (
  input  logic             clk,
  input  logic             rst,
  input  arbPkg::arbStateT nextState,
  input  nocPkg::flitT     inFlitL,
  input  nocPkg::flitT     inFlitN,
  input  nocPkg::flitT     inFlitE,
  input  nocPkg::flitT     inFlitW,
  input  nocPkg::flitT     inFlitS,
  output nocPkg::flitT     outFlit,
  output logic             outValid
);

  nocPkg::flitT selFlit;

  // crossbar leg
  always_comb
  begin
    case (nextState)
      arbPkg::stLocal: selFlit = inFlitL;
      arbPkg::stNorth: selFlit = inFlitN;
      arbPkg::stEast:  selFlit = inFlitE;
      arbPkg::stWest:  selFlit = inFlitW;
      arbPkg::stSouth: selFlit = inFlitS;
      default:         selFlit = '0;  // idle
    endcase
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= (nextState != arbPkg::stIdle);
  end

endmodule

// ==== verilog/outputPort.sv ====
`timescale 1ns/1ps

module outputPort (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flitT  inFlitL,
  input  nocPkg::flitT  inFlitN,
  input  nocPkg::flitT  inFlitE,
  input  nocPkg::flitT  inFlitW,
  input  nocPkg::flitT  inFlitS,
  input  arbPkg::grantT inValid,
  output arbPkg::grantT grant,
  output nocPkg::flitT  outFlit,
  output logic          outValid,
  output arbPkg::grantT framingError
);

  arbPkg::grantT req;
  arbPkg::arbStateT nextState;
  nocPkg::flitIdT flitIdL, flitIdN, flitIdE, flitIdW, flitIdS;
  nocPkg::lengthT lengthL, lengthN, lengthE, lengthW, lengthS;

  assign grant = nextState[arbPkg::numPorts:1];  // drop the idle bit

  // --------------------
  // decoders
  // --------------------
  flitDecode decodeL (
    .clk(clk), .rst(rst), .inFlit(inFlitL), .inValid(inValid[arbPkg::portL]),
    .accepted(grant[arbPkg::portL]), .req(req[arbPkg::portL]), .flitId(flitIdL),
    .length(lengthL), .framingError(framingError[arbPkg::portL])
  );
  flitDecode decodeN (
    .clk(clk), .rst(rst), .inFlit(inFlitN), .inValid(inValid[arbPkg::portN]),
    .accepted(grant[arbPkg::portN]), .req(req[arbPkg::portN]), .flitId(flitIdN),
    .length(lengthN), .framingError(framingError[arbPkg::portN])
  );
  flitDecode decodeE (
    .clk(clk), .rst(rst), .inFlit(inFlitE), .inValid(inValid[arbPkg::portE]),
    .accepted(grant[arbPkg::portE]), .req(req[arbPkg::portE]), .flitId(flitIdE),
    .length(lengthE), .framingError(framingError[arbPkg::portE])
  );
  flitDecode decodeW (
    .clk(clk), .rst(rst), .inFlit(inFlitW), .inValid(inValid[arbPkg::portW]),
    .accepted(grant[arbPkg::portW]), .req(req[arbPkg::portW]), .flitId(flitIdW),
    .length(lengthW), .framingError(framingError[arbPkg::portW])
  );
  flitDecode decodeS (
    .clk(clk), .rst(rst), .inFlit(inFlitS), .inValid(inValid[arbPkg::portS]),
    .accepted(grant[arbPkg::portS]), .req(req[arbPkg::portS]), .flitId(flitIdS),
    .length(lengthS), .framingError(framingError[arbPkg::portS])
  );

  portArbiter arbiter (
    .clk(clk), .rst(rst), .req(req),
    .flitIdL(flitIdL), .flitIdN(flitIdN), .flitIdE(flitIdE),
    .flitIdW(flitIdW), .flitIdS(flitIdS),
    .lengthL(lengthL), .lengthN(lengthN), .lengthE(lengthE),
    .lengthW(lengthW), .lengthS(lengthS),
    .nextState(nextState)
  );

  outputMux mux (
    .clk(clk), .rst(rst), .nextState(nextState),
    .inFlitL(inFlitL), .inFlitN(inFlitN), .inFlitE(inFlitE),
    .inFlitW(inFlitW), .inFlitS(inFlitS),
    .outFlit(outFlit), .outValid(outValid)
  );

endmodule

// ==== verification/outputPort_chk.sv ====
`timescale 1ns/1ps

module outputPort_chk (
  input logic          clk,
  input logic          rst,
  input arbPkg::grantT grant,
  input logic          outValid
);

  // one sender owns the port at a time
  assert property (@(posedge clk) $onehot0(grant))
    else $error("grant has more than one bit set");

  // output register held clear by reset
  assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high during or right after reset");

  // --------------------
  // registered valid follows the grant
  // --------------------
  assert property (@(posedge clk) disable iff (rst) (grant != '0) |=> outValid)
    else $error("outValid low after a granted cycle");

  assert property (@(posedge clk) disable iff (rst) (grant == '0) |=> !outValid)
    else $error("outValid high after a cycle without grant");

endmodule

bind outputPort outputPort_chk chk (
  .clk(clk), .rst(rst), .grant(grant), .outValid(outValid)
);

// ==== verification/outputPortTb.sv ====
`timescale 1ns/1ps

module outputPortTb;

  localparam int randCycles = 3000;
  localparam int waitLimit = 200;  // cycles a pending flit may wait
  localparam int drainLimit = 500;

  logic clk;
  logic rst;
  nocPkg::flitT inFlit [arbPkg::numPorts];
  arbPkg::grantT inValid;
  arbPkg::grantT grant;
  nocPkg::flitT outFlit;
  logic outValid;
  arbPkg::grantT framingError;

  int seed;
  int cycleNum;

  // sender models
  nocPkg::flitT pkt [arbPkg::numPorts][6];
  int pktLen [arbPkg::numPorts];  // 0 when idle
  int pktPos [arbPkg::numPorts];
  int waitCycles [arbPkg::numPorts];
  logic stray [arbPkg::numPorts];
  arbPkg::grantT lastGrant;

  // reference model state
  int mState;  // port index or -1 when idle
  logic mInPacket [arbPkg::numPorts];
  nocPkg::lengthT mLimit [arbPkg::numPorts];
  nocPkg::lengthT mCount [arbPkg::numPorts];
  logic mOutValid;
  nocPkg::flitT mOutFlit;
  arbPkg::grantT mFramingError;

  outputPort DUT (
    .clk(clk), .rst(rst),
    .inFlitL(inFlit[arbPkg::portL]), .inFlitN(inFlit[arbPkg::portN]),
    .inFlitE(inFlit[arbPkg::portE]), .inFlitW(inFlit[arbPkg::portW]),
    .inFlitS(inFlit[arbPkg::portS]),
    .inValid(inValid), .grant(grant), .outFlit(outFlit), .outValid(outValid),
    .framingError(framingError)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int randBelow(input int n);
    randBelow = int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  // first requester from start with wraparound or -1 if none
  function automatic int firstReq(input arbPkg::grantT r, input int start);
    int p;
    firstReq = -1;
    for (int i = 0; i < arbPkg::numPorts; i++)
    begin
      p = (start + i) % arbPkg::numPorts;
      if (firstReq < 0 && r[p])
        firstReq = p;
    end
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      abortRun("value mismatch against the reference model");
    end
  endtask

  // --------------------
  // senders
  // --------------------
  task automatic buildPacket(input int p);
    int bodies;
    nocPkg::flitT raw;
    bodies = randBelow(4);
    raw = nocPkg::flitT'($random(seed));
    raw[nocPkg::idMsb:nocPkg::idLsb] = nocPkg::idHeader;
    raw[nocPkg::lenMsb:nocPkg::lenLsb] = nocPkg::lengthT'(randBelow(8));
    pkt[p][0] = raw;
    for (int b = 1; b <= bodies + 1; b++)
    begin
      raw = nocPkg::flitT'($random(seed));
      raw[nocPkg::idMsb:nocPkg::idLsb] = (b > bodies) ? nocPkg::idTail : nocPkg::idBody;
      pkt[p][b] = raw;
    end
    pktLen[p] = bodies + 2;
    pktPos[p] = 0;
  endtask

  function automatic nocPkg::flitT strayFlit();
    nocPkg::flitT raw;
    raw = nocPkg::flitT'($random(seed));
    case (randBelow(4))
      0: raw[nocPkg::idMsb:nocPkg::idLsb] = nocPkg::idBody;
      1: raw[nocPkg::idMsb:nocPkg::idLsb] = nocPkg::idTail;
      2: raw[nocPkg::idMsb:nocPkg::idLsb] = 3'd3;  // unknown id
      default: raw[nocPkg::idMsb:nocPkg::idLsb] = 3'd7;
    endcase
    strayFlit = raw;
  endfunction

  task automatic updateSenders(input logic gen);
    for (int p = 0; p < arbPkg::numPorts; p++)
    begin
      if (stray[p])
      begin
        stray[p] = 1'b0;  // strays last one cycle and are never granted
        inValid[p] = 1'b0;
      end
      if (lastGrant[p])
      begin
        pktPos[p]++;
        inValid[p] = 1'b0;
        waitCycles[p] = 0;
        if (pktPos[p] == pktLen[p])
          pktLen[p] = 0;
      end
      if (pktLen[p] == 0)
      begin
        inFlit[p] = '0;
        if (gen && randBelow(8) == 0)
          buildPacket(p);
        else if (gen && randBelow(24) == 0)
        begin
          inFlit[p] = strayFlit();
          inValid[p] = 1'b1;
          stray[p] = 1'b1;
        end
      end
      if (pktLen[p] != 0)
      begin
        inFlit[p] = pkt[p][pktPos[p]];
        if (!inValid[p] && randBelow(2) == 0)
          inValid[p] = 1'b1;  // held until granted
        waitCycles[p]++;
        if (waitCycles[p] > waitLimit)
          abortRun($sformatf("sender %0d was never served within %0d cycles", p, waitLimit));
      end
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  task automatic checkCycle();
    arbPkg::grantT req;
    arbPkg::grantT expGrant;
    arbPkg::grantT timesUp;
    nocPkg::flitIdT id;
    int next;
    logic hold;
    checkValue($sformatf("outValid cycle %0d", cycleNum), 32'(mOutValid), 32'(outValid));
    if (mOutValid)
      checkValue($sformatf("outFlit cycle %0d", cycleNum), mOutFlit, outFlit);
    checkValue($sformatf("framingError cycle %0d", cycleNum), 32'(mFramingError),
               32'(framingError));
    for (int p = 0; p < arbPkg::numPorts; p++)
    begin
      id = inFlit[p][nocPkg::idMsb:nocPkg::idLsb];
      req[p] = inValid[p] && (id == nocPkg::idHeader ||
               (mInPacket[p] && (id == nocPkg::idBody || id == nocPkg::idTail)));
      timesUp[p] = (mCount[p] == mLimit[p]);
    end
    hold = (mState >= 0) && req[mState] && !timesUp[mState];
    if (mState < 0)
      next = firstReq(req, 0);
    else if (hold)
      next = mState;
    else
      next = firstReq(req, (mState + 1) % arbPkg::numPorts);
    expGrant = '0;
    if (next >= 0)
      expGrant[next] = 1'b1;
    checkValue($sformatf("grant cycle %0d", cycleNum), 32'(expGrant), 32'(grant));
    lastGrant = grant;

    // clock edge
    mOutValid = (next >= 0);
    mOutFlit = (next >= 0) ? inFlit[next] : '0;
    for (int p = 0; p < arbPkg::numPorts; p++)
    begin
      id = inFlit[p][nocPkg::idMsb:nocPkg::idLsb];
      mFramingError[p] = inValid[p] && !req[p];
      if (expGrant[p] && req[p] && id == nocPkg::idHeader)
        mInPacket[p] = 1'b1;
      else if (expGrant[p] && req[p] && id == nocPkg::idTail)
        mInPacket[p] = 1'b0;
      if (id == nocPkg::idHeader)
        mLimit[p] = inFlit[p][nocPkg::lenMsb:nocPkg::lenLsb];
      if (hold && mState == p)
        mCount[p] = mCount[p] + 12'd1;
      else
        mCount[p] = '0;
    end
    mState = next;
  endtask

  task automatic stepCycle(input logic gen);
    updateSenders(gen);
    #49;  // sample mid-cycle when inputs and grant have settled
    checkCycle();
    cycleNum++;
    @(posedge clk);
    #1;
  endtask

  function automatic logic anyBusy();
    anyBusy = 1'b0;
    for (int p = 0; p < arbPkg::numPorts; p++)
      if (pktLen[p] != 0)
        anyBusy = 1'b1;
  endfunction

  initial
  begin
    int drain;
    seed = 32'h1970164f;
    cycleNum = 0;
    rst = 1'b1;
    inValid = '0;
    lastGrant = '0;
    mState = -1;
    mOutValid = 1'b0;
    mOutFlit = '0;
    mFramingError = '0;
    for (int p = 0; p < arbPkg::numPorts; p++)
    begin
      inFlit[p] = '0;
      pktLen[p] = 0;
      pktPos[p] = 0;
      waitCycles[p] = 0;
      stray[p] = 1'b0;
      mInPacket[p] = 1'b0;
      mLimit[p] = '0;
      mCount[p] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int c = 0; c < randCycles; c++)
      stepCycle(1'b1);

    // queued packets drain with no new traffic
    for (drain = 0; drain < drainLimit && anyBusy(); drain++)
      stepCycle(1'b0);
    if (anyBusy())
      abortRun("queued packets did not drain before the timeout");
    else
    begin
      repeat (20) stepCycle(1'b0);  // grant stays zero while all inputs idle
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
common/nocPkg.sv
common/arbPkg.sv
verilog/flitDecode.sv
arbiter/grantTimer.sv
arbiter/portArbiter.sv
verilog/outputMux.sv
verilog/outputPort.sv
verification/outputPort_chk.sv
verification/outputPortTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
  --top-module outputPortTb -o outputPortSim \
  && ./obj_dir/outputPortSim | tee /dev/stderr | grep -q "Verification passed" \
  && echo "simulation ok" \
  || { echo "simulation did not pass"; exit 1; }
